// ==== cop_pkg.sv ====
package cop_pkg;

    // RAM sizes in 16-bit words
    localparam int SYSRAM_AW = 11;              // 2K words of work RAM
    localparam int PAL_AW    = 9;               // 512 palette words

    localparam logic [15:0] OPEN_BUS = 16'hffff; // nothing drives the bus

    // access targets, also the bit index into the strobe vector
    localparam logic [2:0] TGT_NONE   = 3'd0;
    localparam logic [2:0] TGT_ROM    = 3'd1;
    localparam logic [2:0] TGT_SYSRAM = 3'd2;
    localparam logic [2:0] TGT_PAL    = 3'd3;
    localparam logic [2:0] TGT_PRI    = 3'd4;
    localparam logic [2:0] TGT_IO     = 3'd5;
    localparam logic [2:0] TGT_SND    = 3'd6;
    localparam logic [2:0] TGT_DISP   = 3'd7;

    // registers at 0x180000, word offsets
    localparam logic [2:0] IO_CAB  = 3'd0;      // joysticks + buttons
    localparam logic [2:0] IO_DIP  = 3'd1;      // dip switches
    localparam logic [2:0] IO_SYS  = 3'd4;      // vblank, coins, service
    localparam logic [2:0] IO_VCLR = 3'd5;      // vblank irq ack

    // word address A[23:1] seen as a memory region
    typedef struct packed {
        logic [1:0]  xtra;     // A[23:22], not wired on the board
        logic [1:0]  region;   // A[21:20]
        logic [2:0]  bank;     // A[19:17]
        logic [11:0] page;     // A[16:5]
        logic [3:0]  low;      // A[4:1]
    } cop_adr_rgn_t;

    // same address seen as an I/O register
    typedef struct packed {
        logic [18:0] upper;    // A[23:5]
        logic        io_hi;    // A[4]
        logic [2:0]  io_reg;   // A[3:1]
    } cop_adr_io_t;

    typedef union packed {
        cop_adr_rgn_t rgn;
        cop_adr_io_t  io;
    } cop_addr_u;

    typedef struct packed {
        cop_addr_u   adr;
        logic [15:0] dat;
        logic [1:0]  sel;      // [1] upper byte, [0] lower byte
        logic        we;
    } cop_wb_req_t;

    typedef struct packed {
        logic [2:0] tgt;
        logic [2:0] io_reg;
        logic       valid_io;  // io_reg means something
    } cop_dec_t;

    typedef struct packed {
        logic [7:0]           stb;   // one bit per target code
        logic                 we;
        logic [SYSRAM_AW-1:0] idx;   // word index inside the target
        logic [15:0]          dat;
        logic [1:0]           sel;
    } cop_acc_t;

endpackage

// ==== cop_addr_decoder.sv ====
module cop_addr_decoder (
    input  cop_pkg::cop_wb_req_t req,
    output cop_pkg::cop_dec_t    dec
);

    // map is fixed by the board PALs, A[23:22] are don't care
    always_comb begin
        dec.tgt      = cop_pkg::TGT_NONE;
        dec.io_reg   = req.adr.io.io_reg;       // A[3:1]
        dec.valid_io = 1'b0;

        case (req.adr.rgn.region)
            2'd0: begin
                // program ROM covers the lower half, read only
                if (!req.we && req.adr.rgn.bank < 3'd4) begin
                    dec.tgt = cop_pkg::TGT_ROM;
                end
            end
            2'd1: begin
                case (req.adr.rgn.bank)
                    3'd0: dec.tgt = cop_pkg::TGT_SYSRAM;   // 0x100000, mirrored
                    3'd1: dec.tgt = cop_pkg::TGT_NONE;     // object RAM, not here
                    3'd2: dec.tgt = cop_pkg::TGT_PAL;      // 0x140000
                    3'd3: dec.tgt = cop_pkg::TGT_PRI;      // 0x160000
                    3'd4: begin                             // 0x180000
                        // upper half of each 32-byte block stays silent
                        if (!req.adr.io.io_hi) begin
                            dec.tgt      = cop_pkg::TGT_IO;
                            dec.valid_io = 1'b1;
                        end
                    end
                    3'd5: dec.tgt = cop_pkg::TGT_SND;      // 0x1a0000
                    default: dec.tgt = cop_pkg::TGT_NONE;  // protection, mcu
                endcase
            end
            default: begin
                // both upper regions belong to the BAC06 chips
                dec.tgt = cop_pkg::TGT_DISP;
            end
        endcase
    end

endmodule

// ==== cop_bus_ctrl.sv ====
module cop_bus_ctrl (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  cyc,
    input  wire                  stb,
    input  wire                  we,
    input  wire [22:0]           adr,      // word address A[23:1]
    input  wire [15:0]           dat_w,
    input  wire [1:0]            sel,
    output logic                 ack,
    output logic [15:0]          dat_r,
    output cop_pkg::cop_wb_req_t req,
    input  cop_pkg::cop_dec_t    dec,
    output cop_pkg::cop_acc_t    acc,
    input  wire [15:0]           ram_q,
    input  wire [15:0]           pal_q,
    input  wire [15:0]           io_q,
    input  wire [15:0]           snd_q
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_RESPOND,
        ST_RELEASE
    } state_t;

    state_t      st;
    logic [15:0] rd_mux;
    wire         start = cyc && stb && (st == ST_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st  <= ST_IDLE;
            ack <= 1'b0;
        end else begin
            ack <= 1'b0;                        // single cycle ack
            case (st)
                ST_IDLE:    if (start) st <= ST_ACCESS;
                ST_ACCESS:  st <= ST_RESPOND;   // target samples strobe here
                ST_RESPOND: begin
                    ack <= 1'b1;
                    st  <= ST_RELEASE;
                end
                ST_RELEASE: if (!stb) st <= ST_IDLE; // master must drop stb
                default:    st <= ST_IDLE;
            endcase
        end
    end

    // request held for the whole access
    always_ff @(posedge clk) begin
        if (start) begin
            req.adr <= adr;
            req.dat <= dat_w;
            req.sel <= sel;
            req.we  <= we;
        end
    end

    always_comb begin
        acc.stb = '0;
        if (st == ST_ACCESS) acc.stb[dec.tgt] = 1'b1;  // one hot
        acc.we  = req.we;
        acc.dat = req.dat;
        acc.sel = req.sel;
        // I/O block only needs the register number
        acc.idx = dec.valid_io ? {{(cop_pkg::SYSRAM_AW-3){1'b0}}, dec.io_reg}
                               : req.adr[cop_pkg::SYSRAM_AW-1:0];
    end

    always_comb begin
        case (dec.tgt)
            cop_pkg::TGT_SYSRAM:          rd_mux = ram_q;
            cop_pkg::TGT_PAL:             rd_mux = pal_q;
            cop_pkg::TGT_PRI, cop_pkg::TGT_IO: rd_mux = io_q; // same block
            cop_pkg::TGT_SND:             rd_mux = snd_q;
            default:                      rd_mux = cop_pkg::OPEN_BUS; // rom, disp
        endcase
    end

    always_ff @(posedge clk) begin
        if (st == ST_RESPOND) dat_r <= rd_mux;  // valid with ack
    end

endmodule

// ==== cop_sysram.sv ====
module cop_sysram (
    input  wire               clk,
    input  cop_pkg::cop_acc_t acc,
    output logic [15:0]       q
);

    // 4kB of work RAM, repeats across the 128kB bank
    logic [15:0] mem [0:(1 << cop_pkg::SYSRAM_AW)-1];

    wire cs = acc.stb[cop_pkg::TGT_SYSRAM];

    always_ff @(posedge clk) begin
        if (cs) begin
            if (acc.we) begin
                if (acc.sel[0]) mem[acc.idx][7:0]  <= acc.dat[7:0];   // LDS
                if (acc.sel[1]) mem[acc.idx][15:8] <= acc.dat[15:8];  // UDS
            end
            q <= mem[acc.idx];   // old data on a write cycle
        end
    end

endmodule

// ==== cop_palette.sv ====
module cop_palette (
    input  wire               clk,
    input  cop_pkg::cop_acc_t acc,
    output logic [15:0]       q
);

    logic [15:0]               mem [0:(1 << cop_pkg::PAL_AW)-1];
    logic [cop_pkg::PAL_AW-1:0] pal_a;

    wire cs = acc.stb[cop_pkg::TGT_PAL];

    // only the low bits are decoded, so the colours repeat
    assign pal_a = acc.idx[cop_pkg::PAL_AW-1:0];

    always_ff @(posedge clk) begin
        if (cs) begin
            if (acc.we) begin
                if (acc.sel[0]) mem[pal_a][7:0]  <= acc.dat[7:0];
                if (acc.sel[1]) mem[pal_a][15:8] <= acc.dat[15:8];
            end
            q <= mem[pal_a];   // registered read back
        end
    end

endmodule

// ==== cop_cab_io.sv ====
module cop_cab_io (
    input  wire               clk,
    input  wire               rst_n,
    input  cop_pkg::cop_acc_t acc,
    input  wire [15:0]        joy,
    input  wire [15:0]        dip,
    input  wire               service,
    input  wire [1:0]         coin,
    input  wire               lvbl,      // low during vertical blank
    output logic [15:0]       q,
    output logic [15:0]       pri,
    output logic              vint,
    output logic              obj_copy
);

    logic        lvbl_r;
    logic [15:0] sys_word;

    wire io_cs   = acc.stb[cop_pkg::TGT_IO];
    wire pri_cs  = acc.stb[cop_pkg::TGT_PRI];
    wire vb_fall = lvbl_r && !lvbl;     // blanking starts
    wire vclr    = io_cs && acc.we && (acc.idx[2:0] == cop_pkg::IO_VCLR);

    assign sys_word = {12'd0, service, coin, lvbl_r};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lvbl_r   <= 1'b1;
            vint     <= 1'b0;
            obj_copy <= 1'b0;
            pri      <= 16'd0;
        end else begin
            lvbl_r   <= lvbl;
            obj_copy <= vb_fall;        // one pulse per frame
            if (vb_fall)   vint <= 1'b1; // set wins over clear
            else if (vclr) vint <= 1'b0;
            if (pri_cs && acc.we) begin
                if (acc.sel[0]) pri[7:0]  <= acc.dat[7:0];
                if (acc.sel[1]) pri[15:8] <= acc.dat[15:8];
            end
        end
    end

    // read port, the rest of the block reads zero
    always_ff @(posedge clk) begin
        if (pri_cs) begin
            q <= pri;
        end else if (io_cs) begin
            case (acc.idx[2:0])
                cop_pkg::IO_CAB: q <= joy;
                cop_pkg::IO_DIP: q <= dip;
                cop_pkg::IO_SYS: q <= sys_word;
                default:         q <= 16'd0;  // rotary, vclr
            endcase
        end
    end

endmodule

// ==== cop_sound_latch.sv ====
module cop_sound_latch (
    input  wire               clk,
    input  wire               rst_n,
    input  cop_pkg::cop_acc_t acc,
    output logic [15:0]       q,
    output logic [7:0]        snd_latch,
    output logic              snd_irq      // nmi request to the sound cpu
);

    wire cs  = acc.stb[cop_pkg::TGT_SND];
    wire wr  = cs && acc.we && acc.sel[0];  // byte lane 0 only

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            snd_latch <= 8'd0;
            snd_irq   <= 1'b0;
        end else begin
            snd_irq <= wr;
            if (wr) snd_latch <= acc.dat[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (cs) q <= {8'h00, snd_latch};    // upper byte not driven by the latch
    end

endmodule

// ==== cop_top.sv ====
module cop_top (
    input  wire        clk,
    input  wire        rst_n,
    // main cpu bus
    input  wire        cyc,
    input  wire        stb,
    input  wire        we,
    input  wire [22:0] adr,
    input  wire [15:0] dat_w,
    input  wire [1:0]  sel,
    output logic       ack,
    output logic [15:0] dat_r,
    // cabinet
    input  wire [15:0] joy,
    input  wire [15:0] dip,
    input  wire        service,
    input  wire [1:0]  coin,
    input  wire        lvbl,
    output logic [15:0] pri,
    output logic       vint,
    output logic       obj_copy,
    // sound cpu
    output logic [7:0] snd_latch,
    output logic       snd_irq
);

    cop_pkg::cop_wb_req_t req;
    cop_pkg::cop_dec_t    dec;
    cop_pkg::cop_acc_t    acc;
    logic [15:0]          ram_q, pal_q, io_q, snd_q;

    cop_bus_ctrl u_ctrl (
        .clk, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .sel,
        .ack, .dat_r, .req, .dec, .acc,
        .ram_q, .pal_q, .io_q, .snd_q
    );

    cop_addr_decoder u_dec (.req, .dec);

    cop_sysram u_sysram (.clk, .acc, .q(ram_q));

    cop_palette u_pal (.clk, .acc, .q(pal_q));

    cop_cab_io u_io (
        .clk, .rst_n, .acc, .joy, .dip, .service, .coin, .lvbl,
        .q(io_q), .pri, .vint, .obj_copy
    );

    cop_sound_latch u_snd (.clk, .rst_n, .acc, .q(snd_q), .snd_latch, .snd_irq);

endmodule

// ==== tb_clkgen.sv ====
module tb_clkgen (
    output logic clk
);

    initial clk = 1'b0;

    // half period of 50, full period 100
    always #50 clk = ~clk;

endmodule

// ==== tb_cop.sv ====
module tb_cop;

    logic        clk;
    logic        rst_n;
    logic        cyc, stb, we;
    logic [22:0] adr;
    logic [15:0] dat_w;
    logic [1:0]  sel;
    logic        ack;
    logic [15:0] dat_r;
    logic [15:0] joy, dip, pri;
    logic        service, lvbl, vint, obj_copy, snd_irq;
    logic [1:0]  coin;
    logic [7:0]  snd_latch;

    // shadow copies of every store the bus can reach
    logic [15:0] sys_sh [0:(1 << cop_pkg::SYSRAM_AW)-1];
    logic [15:0] pal_sh [0:(1 << cop_pkg::PAL_AW)-1];
    logic [15:0] pri_sh;
    logic [7:0]  snd_sh;

    integer      seed = 32'h67e1;
    int          errors = 0;
    int          checks = 0;
    int          irq_cnt = 0;
    int          copy_cnt = 0;
    logic [22:0] rd_adr;
    logic [15:0] rd_got, rd_exp;
    event        rd_done;

    tb_clkgen u_clk (.clk);

    cop_top dut0 (.*);

    // pulse counters, sampled on the rising edge
    always @(posedge clk) begin
        if (snd_irq) irq_cnt <= irq_cnt + 1;
        if (obj_copy) copy_cnt <= copy_cnt + 1;
    end

    // compares every finished read against the model
    always @(rd_done) begin
        checks++;
        if (rd_got !== rd_exp) begin
            errors++;
            $display("** Error: dat_r at adr %h = %h, expected %h", rd_adr, rd_got, rd_exp);
        end
    end

    // word address in region 1, bank and 16-bit word offset
    function automatic logic [22:0] r1_adr(input logic [2:0] bank, input logic [15:0] off);
        r1_adr = {2'b00, 2'b01, bank, off};
    endfunction

    function automatic logic [15:0] byte_merge(input logic [15:0] old, input logic [15:0] d,
                                               input logic [1:0] s);
        byte_merge = old;
        if (s[0]) byte_merge[7:0] = d[7:0];    // lower byte lane
        if (s[1]) byte_merge[15:8] = d[15:8];
        return byte_merge;
    endfunction

    // expected read word from the memory map in byte addresses
    function automatic logic [15:0] cop_expect(input logic [22:0] a);
        logic [23:0] b;
        b = {a, 1'b0};
        cop_expect = cop_pkg::OPEN_BUS;        // rom, display, object RAM, holes
        if (b[21:20] == 2'd1) begin
            case (b[19:17])
                3'd0: cop_expect = sys_sh[a[10:0]];   // 2K words, mirrored
                3'd2: cop_expect = pal_sh[a[8:0]];    // 512 words, mirrored
                3'd3: cop_expect = pri_sh;
                3'd4: if (!b[4]) begin
                    case (b[3:1])
                        cop_pkg::IO_CAB: cop_expect = joy;
                        cop_pkg::IO_DIP: cop_expect = dip;
                        cop_pkg::IO_SYS: cop_expect = {12'd0, service, coin, lvbl};
                        default:         cop_expect = 16'h0000;
                    endcase
                end
                3'd5: cop_expect = {8'h00, snd_sh};
                default: ;
            endcase
        end
        return cop_expect;
    endfunction

    task automatic bus_cycle(input logic [22:0] a, input logic w, input logic [15:0] d,
                             input logic [1:0] s, output logic [15:0] q);
        int n;
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= w;
        adr   <= a;
        dat_w <= d;
        sel   <= s;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!ack && n < 16);            // ack expected after 3 edges
        if (!ack) begin
            $display("timeout: no ack within 16 cycles for bus cycle at adr %h", a);
            $display("Simulation failed");
            $finish;
        end else begin
            q = dat_r;                          // valid together with ack
            cyc <= 1'b0;
            stb <= 1'b0;
            we  <= 1'b0;
            @(posedge clk);                     // controller sees stb low
        end
    endtask

    task automatic wb_write(input logic [22:0] a, input logic [15:0] d, input logic [1:0] s);
        logic [15:0] q;
        bus_cycle(a, 1'b1, d, s, q);
    endtask

    task automatic wb_read(input logic [22:0] a);
        logic [15:0] q;
        bus_cycle(a, 1'b0, 16'h0000, 2'b11, q);
        rd_adr = a;
        rd_got = q;
        rd_exp = cop_expect(a);
        -> rd_done;
    endtask

    // shadow update by the map rules, then the real bus write
    task automatic model_write(input logic [22:0] a, input logic [15:0] d, input logic [1:0] s);
        logic [23:0] b;
        b = {a, 1'b0};
        if (b[21:20] == 2'd1) begin
            case (b[19:17])
                3'd0: sys_sh[a[10:0]] = byte_merge(sys_sh[a[10:0]], d, s);
                3'd2: pal_sh[a[8:0]] = byte_merge(pal_sh[a[8:0]], d, s);
                3'd3: pri_sh = byte_merge(pri_sh, d, s);
                3'd5: if (s[0]) snd_sh = d[7:0];   // low byte lane only
                default: ;
            endcase
        end
        wb_write(a, d, s);
    endtask

    task automatic check_value(input string sig, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h", sig, got, exp);
        end
    endtask

    task automatic report(input string name, input int e0);
        @(posedge clk);                         // lets the last compare run
        if (errors == e0) $display("test %-20s ok", name);
        else $display("test %-20s FAIL, %0d errors", name, errors - e0);
    endtask

    initial begin
        int          i, j, n, e0, c0;
        logic [31:0] r;
        logic [22:0] a;
        logic [10:0] sidx [0:23];
        logic [8:0]  pidx [0:15];
        rst_n   = 1'b0;
        cyc     = 1'b0;
        stb     = 1'b0;
        we      = 1'b0;
        adr     = '0;
        dat_w   = '0;
        sel     = '0;
        joy     = 16'h0000;
        dip     = 16'h0000;
        service = 1'b0;
        coin    = 2'b00;
        lvbl    = 1'b1;                         // outside blanking
        pri_sh  = 16'h0000;
        snd_sh  = 8'h00;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        e0 = errors;
        check_value("ack", ack, 0);
        check_value("vint", vint, 0);
        check_value("obj_copy", obj_copy, 0);
        check_value("snd_irq", snd_irq, 0);
        check_value("pri", pri, 0);
        check_value("snd_latch", snd_latch, 0);
        report("reset", e0);

        e0 = errors;
        for (i = 0; i < 24; i++) begin
            r = $random(seed);
            sidx[i] = r[10:0];
            model_write(r1_adr(3'd0, r[15:0]), r[31:16], 2'b11);  // full word first
        end
        for (i = 0; i < 40; i++) begin
            r = $random(seed);
            j = r[4:0] % 24;
            model_write(r1_adr(3'd0, {r[9:5], sidx[j]}), r[31:16], r[11:10]);
        end
        for (i = 0; i < 24; i++) begin
            r = $random(seed);
            wb_read(r1_adr(3'd0, {r[4:0], sidx[i]}));   // other mirror
        end
        report("sysram", e0);

        e0 = errors;
        for (i = 0; i < 16; i++) begin
            r = $random(seed);
            pidx[i] = sidx[i][8:0];             // same low bits as a sysram word
            model_write(r1_adr(3'd2, {r[15:9], pidx[i]}), r[31:16], 2'b11);
            r = $random(seed);
            model_write(r1_adr(3'd2, {r[6:0], pidx[i]}), r[31:16], r[9:8]);
        end
        for (i = 0; i < 16; i++) begin
            r = $random(seed);
            wb_read(r1_adr(3'd2, {r[6:0], pidx[i]}));
        end
        for (i = 0; i < 6; i++) begin
            r = $random(seed);
            model_write(r1_adr(3'd3, r[15:0]), r[31:16], i[1:0]);
            check_value("pri", pri, pri_sh);
            wb_read(r1_adr(3'd3, r[15:0] ^ 16'h5a5a));
        end
        report("palette and priority", e0);

        e0 = errors;
        for (i = 0; i < 4; i++) begin
            r = $random(seed);
            joy     <= r[15:0];
            dip     <= r[31:16];
            coin    <= r[5:4];
            service <= r[6];
            r = $random(seed);
            wb_read(r1_adr(3'd4, {r[27:16], 1'b0, cop_pkg::IO_CAB}));
            wb_read(r1_adr(3'd4, {r[27:16], 1'b0, cop_pkg::IO_DIP}));
            wb_read(r1_adr(3'd4, {r[27:16], 1'b0, cop_pkg::IO_SYS}));
            wb_read(r1_adr(3'd4, {r[11:0], 1'b0, r[14:12]}));
            wb_read(r1_adr(3'd4, {r[11:0], 1'b1, r[14:12]}));   // A[4] high, silent
        end
        report("cabinet io", e0);

        e0 = errors;
        c0 = copy_cnt;
        lvbl <= 1'b0;                           // blanking starts
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!vint && n < 10);
        if (!vint) begin
            errors++;
            $display("vint did not rise within 10 cycles of lvbl falling");
        end
        repeat (4) @(posedge clk);              // room for a stray second pulse
        check_value("obj_copy pulses", copy_cnt - c0, 1);
        wb_read(r1_adr(3'd4, {12'h000, 1'b0, cop_pkg::IO_SYS}));
        model_write(r1_adr(3'd4, {12'h000, 1'b0, cop_pkg::IO_VCLR}), 16'h0000, 2'b11);
        check_value("vint", vint, 0);
        lvbl <= 1'b1;
        repeat (4) @(posedge clk);
        check_value("obj_copy pulses", copy_cnt - c0, 1);   // none on the rising edge
        check_value("vint", vint, 0);
        report("vblank", e0);

        e0 = errors;
        for (i = 0; i < 3; i++) begin
            c0 = irq_cnt;
            r = $random(seed);
            model_write(r1_adr(3'd5, r[31:16]), r[15:0], 2'b01);
            check_value("snd_latch", snd_latch, snd_sh);
            check_value("snd_irq pulses", irq_cnt - c0, 1);
            model_write(r1_adr(3'd5, 16'h0000), ~r[15:0], 2'b10);  // upper lane ignored
            check_value("snd_latch", snd_latch, snd_sh);
            check_value("snd_irq pulses", irq_cnt - c0, 1);
            wb_read(r1_adr(3'd5, r[15:0]));
        end
        report("sound latch", e0);

        e0 = errors;
        for (i = 0; i < 12; i++) begin
            r = $random(seed);
            case (i % 6)
                0: a = {r[22:21], 2'd0, 1'b0, r[17:0]};    // rom
                1: a = {r[22:21], 2'd0, 1'b1, r[17:0]};    // above rom
                2: a = {r[22:21], 1'b1, r[19:0]};          // display
                3: a = r1_adr(3'd1, r[15:0]);              // object RAM
                4: a = r1_adr({2'b11, r[16]}, r[15:0]);    // protection, mcu
                default: a = r1_adr(3'd4, {r[15:4], 1'b1, r[2:0]});
            endcase
            if (i % 6 != 5) a[10:0] = sidx[i];   // stray write would hit a checked word
            model_write(a, ~r[15:0], 2'b11);
            wb_read(a);
        end
        for (i = 0; i < 12; i++) begin
            wb_read(r1_adr(3'd0, {5'd0, sidx[i]}));
            wb_read(r1_adr(3'd2, {7'd0, pidx[i]}));
        end
        wb_read(r1_adr(3'd3, 16'h0000));
        wb_read(r1_adr(3'd5, 16'h0000));
        check_value("pri", pri, pri_sh);
        check_value("snd_latch", snd_latch, snd_sh);
        report("open bus", e0);

        @(posedge clk);
        $display("%0d reads compared, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
cop_pkg.sv
cop_addr_decoder.sv
cop_bus_ctrl.sv
cop_sysram.sv
cop_palette.sv
cop_cab_io.sv
cop_sound_latch.sv
cop_top.sv
tb_clkgen.sv
tb_cop.sv
